/* common/procPkg.sv */
// Shared ISA definitions for the pipelined processor, imported by every stage module
`default_nettype none

package procPkg;

   // Datapath and register index widths
   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;

   // Opcodes 8 to 15 are illegal
   typedef enum logic [3:0] {
      opNop   = 4'd0,
      opRtype = 4'd1,
      opAddi  = 4'd2,
      opLd    = 4'd3,
      opSt    = 4'd4,
      opBeqz  = 4'd5,
      opBnez  = 4'd6,
      opHalt  = 4'd7
   } opcodeT;

   // R-type functions, 5 to 7 are illegal
   typedef enum logic [2:0] {
      fnAdd = 3'd0,
      fnSub = 3'd1,
      fnAnd = 3'd2,
      fnOr  = 3'd3,
      fnXor = 3'd4
   } functT;

   // Register to register format
   typedef struct packed {
      logic [3:0] opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] funct;
   } rFormatT;

   // Immediate format, also used by loads, stores and branches
   typedef struct packed {
      logic [3:0] opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [5:0] imm6;
   } iFormatT;

   // One instruction word seen through either format
   typedef union packed {
      rFormatT r;
      iFormatT i;
   } instrT;

   // All-zero word decodes as NOP
   localparam instrT nopWord = '0;

endpackage

`default_nettype wire

/* fetch/fetch.sv */
// Fetch stage with PC, loadable instruction memory and next-PC selection
`timescale 1ns/100ps
`default_nettype none

module fetch #(
   parameter int imemAddrBits = 6
) (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          progWe,
   input  logic [imemAddrBits-1:0]       progAddr,
   input  logic [procPkg::dataWidth-1:0] progData,
   input  logic                          stallD,
   input  logic                          haltD,
   input  logic                          branchTaken,
   input  logic [procPkg::dataWidth-1:0] branchTarget,
   output logic [procPkg::dataWidth-1:0] pcF,
   output procPkg::instrT                instrF,
   output logic                          validF
);
   import procPkg::*;

   logic [dataWidth-1:0] imem [2**imemAddrBits];
   logic                 haltReg;
   logic                 stopped;

   // Program image goes in only while the core is held in reset
   always_ff @(posedge clk) begin
      if (!rstN && progWe) begin
         imem[progAddr] <= progData;
      end
   end

   // Stop feeding instructions once HALT has been seen in decode
   assign stopped = haltReg | haltD;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pcF     <= '0;
         haltReg <= 1'b0;
      end else begin
         // A taken branch also cancels a HALT sitting in decode
         if (branchTaken) begin
            pcF <= branchTarget;
         end else if (!(stallD || stopped)) begin
            pcF <= pcF + dataWidth'(1);
         end
         if (haltD && !branchTaken) begin
            haltReg <= 1'b1;
         end
      end
   end

   assign instrF = stopped ? nopWord : imem[pcF[imemAddrBits-1:0]];
   assign validF = !stopped;

endmodule

`default_nettype wire

/* src/stageReg.sv */
// Pipeline stage register with hold and bubble, bit 0 carries the valid flag
`timescale 1ns/100ps
`default_nettype none

module stageReg #(
   parameter int width = 1
) (
   input  logic             clk,
   input  logic             rstN,
   input  logic             hold,
   input  logic             bubble,
   input  logic [width-1:0] d,
   output logic [width-1:0] q
);

   // All zeros means invalid slot with a NOP instruction
   always_ff @(posedge clk) begin
      if (!rstN || bubble) begin
         q <= '0;
      end else if (!hold) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

/* decode/decode.sv */
// Decode stage with register file, load-use stall, halt detect and sticky error flag
`timescale 1ns/100ps
`default_nettype none

module decode (
   input  logic                             clk,
   input  logic                             rstN,
   input  procPkg::instrT                   instrD,
   input  logic                             validD,
   input  logic [procPkg::regAddrWidth-1:0] rdX,
   input  logic                             loadX,
   input  logic                             validX,
   input  logic                             validW,
   input  logic                             haltW,
   input  logic                             regWrtW,
   input  logic [procPkg::regAddrWidth-1:0] wrtRegW,
   input  logic [procPkg::dataWidth-1:0]    wbDataW,
   output logic [3:0]                       opD,
   output logic [2:0]                       functD,
   output logic [procPkg::regAddrWidth-1:0] rdD,
   output logic [procPkg::regAddrWidth-1:0] rsD,
   output logic [procPkg::regAddrWidth-1:0] rtD,
   output logic [procPkg::dataWidth-1:0]    srcAD,
   output logic [procPkg::dataWidth-1:0]    srcBD,
   output logic [procPkg::dataWidth-1:0]    immD,
   output logic                             regWrtD,
   output logic                             loadD,
   output logic                             stallD,
   output logic                             haltD,
   output logic                             wbValid,
   output logic                             halted,
   output logic                             err
);
   import procPkg::*;

   logic [dataWidth-1:0]    regs [2**regAddrWidth];
   instrT                   instrE;
   opcodeT                  op;
   logic                    illegal;
   logic                    readsA;
   logic                    readsB;
   logic [regAddrWidth-1:0] bIdx;
   logic                    wrtEn;
   logic                    haltedReg;

   // Bad opcode or bad function, the instruction then runs as NOP
   assign illegal = validD &&
                    (instrD.r.opcode[3] ||
                     (instrD.r.opcode == opRtype && instrD.r.funct > fnXor));
   assign instrE  = illegal ? nopWord : instrD;
   assign op      = opcodeT'(instrE.r.opcode);

   assign opD    = op;
   assign functD = instrE.r.funct;
   assign rdD    = instrE.r.rd;
   assign rsD    = instrE.r.rs;
   assign rtD    = instrE.r.rt;
   assign immD   = {{(dataWidth-6){instrE.i.imm6[5]}}, instrE.i.imm6};

   // Second operand is rt for R type, rd for stores and branches
   assign readsA = op inside {opRtype, opAddi, opLd, opSt};
   assign readsB = op inside {opRtype, opSt, opBeqz, opBnez};
   assign bIdx   = (op == opRtype) ? rtD : rdD;

   assign regWrtD = validD && (op inside {opRtype, opAddi, opLd});
   assign loadD   = (op == opLd);
   assign haltD   = validD && (op == opHalt);

   // Load in execute feeding this instruction costs one bubble
   assign stallD = validD && validX && loadX &&
                   ((readsA && rsD == rdX) || (readsB && bIdx == rdX));

   assign wrtEn   = validW && regWrtW;
   assign wbValid = wrtEn;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (wrtEn) begin
         regs[wrtRegW] <= wbDataW;
      end
   end

   // Same-cycle writeback is visible to the read
   assign srcAD = (wrtEn && wrtRegW == rsD) ? wbDataW : regs[rsD];
   assign srcBD = (wrtEn && wrtRegW == bIdx) ? wbDataW : regs[bIdx];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         err       <= 1'b0;
         haltedReg <= 1'b0;
      end else begin
         if (illegal) begin
            err <= 1'b1;
         end
         if (validW && haltW) begin
            haltedReg <= 1'b1;
         end
      end
   end

   // High from the cycle HALT sits in writeback
   assign halted = haltedReg | (validW && haltW);

endmodule

`default_nettype wire

/* execute/execute.sv */
// Execute stage with operand forwarding, ALU and branch resolution
`timescale 1ns/100ps
`default_nettype none

module execute (
   input  logic [3:0]                       opX,
   input  logic [2:0]                       functX,
   input  logic [procPkg::regAddrWidth-1:0] rdX,
   input  logic [procPkg::regAddrWidth-1:0] rsX,
   input  logic [procPkg::regAddrWidth-1:0] rtX,
   input  logic [procPkg::dataWidth-1:0]    srcAX,
   input  logic [procPkg::dataWidth-1:0]    srcBX,
   input  logic [procPkg::dataWidth-1:0]    immX,
   input  logic [procPkg::dataWidth-1:0]    pcX,
   input  logic                             validX,
   input  logic [procPkg::dataWidth-1:0]    resultM,
   input  logic [procPkg::regAddrWidth-1:0] wrtRegM,
   input  logic                             regWrtM,
   input  logic [procPkg::dataWidth-1:0]    wbDataW,
   input  logic [procPkg::regAddrWidth-1:0] wrtRegW,
   input  logic                             regWrtW,
   output logic [procPkg::dataWidth-1:0]    aluOutX,
   output logic [procPkg::dataWidth-1:0]    storeDataX,
   output logic                             branchTaken,
   output logic [procPkg::dataWidth-1:0]    branchTarget,
   output logic                             flushX
);
   import procPkg::*;

   functT                   fn;
   logic [regAddrWidth-1:0] bIdx;
   logic [dataWidth-1:0]    opA;
   logic [dataWidth-1:0]    opB;
   logic                    bZero;

   assign fn   = functT'(functX);
   assign bIdx = (opX == opRtype) ? rtX : rdX;

   // Youngest producer wins, memory stage before writeback
   assign opA = (regWrtM && wrtRegM == rsX) ? resultM :
                (regWrtW && wrtRegW == rsX) ? wbDataW :
                srcAX;
   assign opB = (regWrtM && wrtRegM == bIdx) ? resultM :
                (regWrtW && wrtRegW == bIdx) ? wbDataW :
                srcBX;

   always_comb begin
      case (opX)
         opRtype: begin
            case (fn)
               fnAdd:   aluOutX = opA + opB;
               fnSub:   aluOutX = opA - opB;
               fnAnd:   aluOutX = opA & opB;
               fnOr:    aluOutX = opA | opB;
               fnXor:   aluOutX = opA ^ opB;
               default: aluOutX = '0;
            endcase
         end
         // Effective address shares the immediate adder
         opAddi, opLd, opSt: aluOutX = opA + immX;
         default:            aluOutX = '0;
      endcase
   end

   assign storeDataX = opB;

   // Branch tests the forwarded rd value
   assign bZero        = (opB == '0);
   assign branchTaken  = validX &&
                         ((opX == opBeqz && bZero) || (opX == opBnez && !bZero));
   assign branchTarget = pcX + dataWidth'(1) + immX;
   assign flushX       = branchTaken;

endmodule

`default_nettype wire

/* memory/memory.sv */
// Memory stage with single-cycle data memory and stage result select
`timescale 1ns/100ps
`default_nettype none

module memory #(
   parameter int dmemAddrBits = 6
) (
   input  logic                          clk,
   input  logic [3:0]                    opM,
   input  logic                          validM,
   input  logic [procPkg::dataWidth-1:0] aluOutM,
   input  logic [procPkg::dataWidth-1:0] storeDataM,
   output logic [procPkg::dataWidth-1:0] resultM
);
   import procPkg::*;

   logic [dataWidth-1:0]    dmem [2**dmemAddrBits];
   logic [dmemAddrBits-1:0] addr;

   // Word address, upper bits wrap
   assign addr = aluOutM[dmemAddrBits-1:0];

   always_ff @(posedge clk) begin
      if (validM && opM == opSt) begin
         dmem[addr] <= storeDataM;
      end
   end

   // Asynchronous read so loads forward from this stage
   assign resultM = (opM == opLd) ? dmem[addr] : aluOutM;

endmodule

`default_nettype wire

/* src/proc.sv */
// Top level of the five-stage processor, wiring stages and pipeline registers together
`timescale 1ns/100ps
`default_nettype none

module proc #(
   parameter int imemAddrBits = 6,
   parameter int dmemAddrBits = 6
) (
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             progWe,
   input  logic [imemAddrBits-1:0]          progAddr,
   input  logic [procPkg::dataWidth-1:0]    progData,
   output logic                             err,
   output logic                             halted,
   output logic                             wbValid,
   output logic [procPkg::regAddrWidth-1:0] wbReg,
   output logic [procPkg::dataWidth-1:0]    wbData
);
   import procPkg::*;

   localparam int fdWidth = 2*dataWidth + 1;
   localparam int dxWidth = 4*dataWidth + 4 + 3 + 3*regAddrWidth + 4;
   localparam int xmWidth = 2*dataWidth + 4 + regAddrWidth + 3;
   localparam int mwWidth = dataWidth + regAddrWidth + 3;

   // Fetch and decode side
   logic [dataWidth-1:0]    pcF, pcD, pcX;
   instrT                   instrF, instrD;
   logic                    validF, validD, validX, validM, validW;
   logic                    stallD, haltD, flushX, branchTaken;
   logic [dataWidth-1:0]    branchTarget;

   // Decode outputs and their execute copies
   logic [3:0]              opD, opX, opM;
   logic [2:0]              functD, functX;
   logic [regAddrWidth-1:0] rdD, rsD, rtD, rdX, rsX, rtX;
   logic [dataWidth-1:0]    srcAD, srcBD, immD, srcAX, srcBX, immX;
   logic                    regWrtD, loadD, regWrtX, loadX, haltX;

   // Execute, memory and writeback side
   logic [dataWidth-1:0]    aluOutX, storeDataX, aluOutM, storeDataM, resultM;
   logic [regAddrWidth-1:0] wrtRegM;
   logic                    regWrtM, haltM, regWrtW, haltW;

   fetch #(.imemAddrBits(imemAddrBits)) fetchStage (
      .clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .stallD(stallD), .haltD(haltD), .branchTaken(branchTaken),
      .branchTarget(branchTarget), .pcF(pcF), .instrF(instrF), .validF(validF));

   stageReg #(.width(fdWidth)) fetchToDecode (
      .clk(clk), .rstN(rstN), .hold(stallD), .bubble(flushX),
      .d({pcF, instrF, validF}), .q({pcD, instrD, validD}));

   decode decodeStage (
      .clk(clk), .rstN(rstN), .instrD(instrD), .validD(validD),
      .rdX(rdX), .loadX(loadX), .validX(validX), .validW(validW), .haltW(haltW),
      .regWrtW(regWrtW), .wrtRegW(wbReg), .wbDataW(wbData),
      .opD(opD), .functD(functD), .rdD(rdD), .rsD(rsD), .rtD(rtD),
      .srcAD(srcAD), .srcBD(srcBD), .immD(immD), .regWrtD(regWrtD), .loadD(loadD),
      .stallD(stallD), .haltD(haltD), .wbValid(wbValid), .halted(halted), .err(err));

   // Stall and flush both turn the execute slot into a bubble
   stageReg #(.width(dxWidth)) decodeToExecute (
      .clk(clk), .rstN(rstN), .hold(1'b0), .bubble(stallD | flushX),
      .d({pcD, immD, srcAD, srcBD, opD, functD, rdD, rsD, rtD,
          regWrtD, loadD, haltD, validD}),
      .q({pcX, immX, srcAX, srcBX, opX, functX, rdX, rsX, rtX,
          regWrtX, loadX, haltX, validX}));

   execute executeStage (
      .opX(opX), .functX(functX), .rdX(rdX), .rsX(rsX), .rtX(rtX),
      .srcAX(srcAX), .srcBX(srcBX), .immX(immX), .pcX(pcX), .validX(validX),
      .resultM(resultM), .wrtRegM(wrtRegM), .regWrtM(regWrtM),
      .wbDataW(wbData), .wrtRegW(wbReg), .regWrtW(regWrtW),
      .aluOutX(aluOutX), .storeDataX(storeDataX), .branchTaken(branchTaken),
      .branchTarget(branchTarget), .flushX(flushX));

   stageReg #(.width(xmWidth)) executeToMemory (
      .clk(clk), .rstN(rstN), .hold(1'b0), .bubble(1'b0),
      .d({aluOutX, storeDataX, opX, rdX, regWrtX, haltX, validX}),
      .q({aluOutM, storeDataM, opM, wrtRegM, regWrtM, haltM, validM}));

   memory #(.dmemAddrBits(dmemAddrBits)) memoryStage (
      .clk(clk), .opM(opM), .validM(validM), .aluOutM(aluOutM),
      .storeDataM(storeDataM), .resultM(resultM));

   // Writeback fields drive the top outputs directly
   stageReg #(.width(mwWidth)) memoryToWriteback (
      .clk(clk), .rstN(rstN), .hold(1'b0), .bubble(1'b0),
      .d({resultM, wrtRegM, regWrtM, haltM, validM}),
      .q({wbData, wbReg, regWrtW, haltW, validW}));

endmodule

`default_nettype wire

/* bench/procTb.sv */
// Directed testbench for the pipelined processor, compares writebacks with an ISA reference model
`timescale 1ns/100ps
`default_nettype none

module procTb;
   import procPkg::*;

   localparam int clkPeriod     = 4;
   localparam int imemBits      = 6;
   localparam int dmemBits      = 6;
   localparam int imemWords     = 2**imemBits;
   localparam int dmemWords     = 2**dmemBits;
   localparam int numTests      = 5;
   localparam int cyclesPerTest = 200;

   logic                    clk;
   logic                    rstN;
   logic                    progWe;
   logic [imemBits-1:0]     progAddr;
   logic [dataWidth-1:0]    progData;
   logic                    err;
   logic                    halted;
   logic                    wbValid;
   logic [regAddrWidth-1:0] wbReg;
   logic [dataWidth-1:0]    wbData;

   // Program under test and the ordered register writes the model predicts
   logic [15:0] prog [$];
   logic [2:0]  expReg [$];
   logic [15:0] expData [$];

   proc #(.imemAddrBits(imemBits), .dmemAddrBits(dmemBits)) UUT (
      .clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .err(err), .halted(halted), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

   initial begin
      clk = 1'b0;
      forever #(clkPeriod/2) clk = ~clk;
   end

   // Each test gets its run budget plus the longest possible program load
   initial begin
      #(numTests * (cyclesPerTest + imemWords) * clkPeriod);
      stopOnFailure("watchdog expired before all tests finished");
   end

   task automatic stopOnFailure(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "run stopped after a failed check");
   endtask

   task automatic checkValue(input string sig, input logic [15:0] expected,
                             input logic [15:0] got);
      assert (got === expected) else begin
         $display("mismatch at %0t ns: %s expected %0h got %0h", $time, sig, expected, got);
         stopOnFailure("writeback or status value differs from the model");
      end
   endtask

   task automatic putR(input logic [2:0] fn, input logic [2:0] rd, input logic [2:0] rs,
                       input logic [2:0] rt);
      prog.push_back({opRtype, rd, rs, rt, fn});
   endtask

   task automatic putI(input logic [3:0] op, input logic [2:0] rd, input logic [2:0] rs,
                       input int imm);
      prog.push_back({op, rd, rs, imm[5:0]});
   endtask

   // Instruction-level execution of the program, fills the expected write list
   task automatic runModel();
      logic [15:0] regsM [8];
      logic [15:0] memM [dmemWords];
      logic [15:0] word;
      logic [15:0] imm;
      logic [15:0] ea;
      logic [15:0] val;
      logic [3:0]  op;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic [2:0]  fn;
      bit          writes;
      bit          done;
      int          pc;
      int          steps;
      expReg.delete();
      expData.delete();
      foreach (regsM[i]) regsM[i] = '0;
      pc = 0;
      steps = 0;
      done = 1'b0;
      while (!done) begin
         if (steps > 1000 || pc < 0 || pc >= prog.size()) begin
            stopOnFailure("reference model ran off the program without a HALT");
         end
         word = prog[pc];
         op = word[15:12];
         rd = word[11:9];
         rs = word[8:6];
         rt = word[5:3];
         fn = word[2:0];
         imm = {{10{word[5]}}, word[5:0]};
         ea = regsM[rs] + imm;
         writes = 1'b0;
         val = '0;
         pc++;
         steps++;
         case (op)
            4'd1: begin
               // Functions 5 to 7 behave as NOP
               writes = (fn <= 3'd4);
               case (fn)
                  3'd0: val = regsM[rs] + regsM[rt];
                  3'd1: val = regsM[rs] - regsM[rt];
                  3'd2: val = regsM[rs] & regsM[rt];
                  3'd3: val = regsM[rs] | regsM[rt];
                  3'd4: val = regsM[rs] ^ regsM[rt];
                  default: val = '0;
               endcase
            end
            4'd2: begin
               writes = 1'b1;
               val = ea;
            end
            4'd3: begin
               writes = 1'b1;
               val = memM[ea[dmemBits-1:0]];
            end
            4'd4: memM[ea[dmemBits-1:0]] = regsM[rd];
            4'd5: if (regsM[rd] == '0) pc = pc + int'($signed(word[5:0]));
            4'd6: if (regsM[rd] != '0) pc = pc + int'($signed(word[5:0]));
            4'd7: done = 1'b1;
            default: ;
         endcase
         if (writes) begin
            regsM[rd] = val;
            expReg.push_back(rd);
            expData.push_back(val);
         end
      end
   endtask

   // Load during reset, release, then follow the writeback port until HALT retires
   task automatic runProgram(input string name, input bit expectErr);
      logic [2:0]  wantReg;
      logic [15:0] wantData;
      int          cycles;
      bit          errSeen;
      runModel();
      prog.push_back(16'h0000);
      prog.push_back(16'h0000);
      @(posedge clk);
      rstN <= 1'b0;
      foreach (prog[i]) begin
         @(posedge clk);
         progWe   <= 1'b1;
         progAddr <= imemBits'(i);
         progData <= prog[i];
      end
      @(posedge clk);
      progWe <= 1'b0;
      @(posedge clk);
      rstN <= 1'b1;
      cycles = 0;
      errSeen = 1'b0;
      do begin
         @(negedge clk);
         cycles++;
         assert (cycles < cyclesPerTest) else
            stopOnFailure($sformatf("%s: HALT did not retire within the cycle budget", name));
         if (wbValid) begin
            assert (expReg.size() > 0) else
               stopOnFailure($sformatf("%s: extra write to r%0d after the model's last", name, wbReg));
            wantReg = expReg.pop_front();
            wantData = expData.pop_front();
            checkValue("wbReg", 16'(wantReg), 16'(wbReg));
            checkValue("wbData", wantData, wbData);
         end
         if (errSeen || !expectErr) begin
            checkValue("err", 16'(errSeen), 16'(err));
         end
         errSeen = errSeen | (err === 1'b1);
      end while (halted !== 1'b1);
      // Nothing retires after HALT and the status flags hold
      repeat (3) begin
         @(negedge clk);
         assert (wbValid === 1'b0) else
            stopOnFailure($sformatf("%s: a register write retired after HALT", name));
         checkValue("halted", 16'h1, 16'(halted));
      end
      assert (expReg.size() == 0) else
         stopOnFailure($sformatf("%s: %0d expected writes never retired", name, expReg.size()));
      checkValue("err", 16'(expectErr), 16'(err));
      $display("%s done in %0d cycles", name, cycles);
   endtask

   task automatic testAluChain();
      prog.delete();
      putI(opAddi, 3'd1, 3'd0, 5);
      putI(opAddi, 3'd2, 3'd1, -3);
      putR(fnAdd, 3'd3, 3'd1, 3'd2);
      putR(fnSub, 3'd4, 3'd3, 3'd1);
      putR(fnAnd, 3'd5, 3'd4, 3'd3);
      putR(fnOr, 3'd6, 3'd5, 3'd1);
      putR(fnXor, 3'd7, 3'd6, 3'd3);
      putI(opAddi, 3'd0, 3'd7, 31);
      putR(fnSub, 3'd1, 3'd0, 3'd6);
      putR(fnAdd, 3'd2, 3'd1, 3'd1);
      putI(opHalt, 3'd0, 3'd0, 0);
      runProgram("alu chain", 1'b0);
   endtask

   task automatic testLoadStore();
      prog.delete();
      putI(opAddi, 3'd1, 3'd0, 10);
      putI(opAddi, 3'd2, 3'd0, -7);
      putI(opSt, 3'd1, 3'd0, 3);
      putI(opSt, 3'd2, 3'd1, 4);
      putI(opAddi, 3'd3, 3'd0, 20);
      putI(opSt, 3'd3, 3'd1, -2);
      putI(opLd, 3'd4, 3'd0, 3);
      // Dependent add right after the load stalls one cycle
      putR(fnAdd, 3'd5, 3'd4, 3'd1);
      putI(opLd, 3'd6, 3'd1, 4);
      putI(opSt, 3'd6, 3'd0, 20);
      putI(opLd, 3'd7, 3'd3, 0);
      putI(opLd, 3'd1, 3'd0, 8);
      putR(fnAdd, 3'd2, 3'd7, 3'd1);
      putI(opHalt, 3'd0, 3'd0, 0);
      runProgram("load store", 1'b0);
   endtask

   task automatic testBranches();
      prog.delete();
      putI(opAddi, 3'd1, 3'd0, 3);
      putI(opAddi, 3'd2, 3'd0, 0);
      putR(fnAdd, 3'd2, 3'd2, 3'd1);
      putI(opAddi, 3'd1, 3'd1, -1);
      putI(opBnez, 3'd1, 3'd0, -3);
      putI(opBeqz, 3'd0, 3'd0, 2);
      putI(opAddi, 3'd3, 3'd0, 11);
      putI(opAddi, 3'd4, 3'd0, 12);
      putI(opBnez, 3'd0, 3'd0, 1);
      putI(opAddi, 3'd5, 3'd0, 1);
      putI(opBeqz, 3'd5, 3'd0, 2);
      putI(opBnez, 3'd5, 3'd0, 2);
      putI(opAddi, 3'd6, 3'd0, 9);
      putI(opAddi, 3'd7, 3'd0, 9);
      putI(opAddi, 3'd3, 3'd2, 0);
      putI(opHalt, 3'd0, 3'd0, 0);
      runProgram("branches", 1'b0);
   endtask

   task automatic testIllegal();
      prog.delete();
      putI(opAddi, 3'd1, 3'd0, 6);
      putI(4'd9, 3'd1, 3'd1, 1);
      putI(opAddi, 3'd2, 3'd1, 1);
      putR(3'd6, 3'd3, 3'd1, 3'd2);
      putR(fnAdd, 3'd3, 3'd1, 3'd2);
      putI(opHalt, 3'd0, 3'd0, 0);
      runProgram("illegal instructions", 1'b1);
   endtask

   task automatic testRandom();
      int kind;
      prog.delete();
      repeat (40) begin
         kind = $urandom_range(0, 7);
         if (kind < 5) begin
            putR(3'(kind), 3'($urandom_range(0, 7)), 3'($urandom_range(0, 7)),
                 3'($urandom_range(0, 7)));
         end else begin
            putI(opAddi, 3'($urandom_range(0, 7)), 3'($urandom_range(0, 7)),
                 int'($urandom_range(0, 63)));
         end
      end
      putI(opHalt, 3'd0, 3'd0, 0);
      runProgram("random alu program", 1'b0);
   endtask

   initial begin
      void'($urandom(68104));
      rstN     = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      repeat (3) @(posedge clk);
      testAluChain();
      testLoadStore();
      testBranches();
      testIllegal();
      testRandom();
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
common/procPkg.sv
fetch/fetch.sv
src/stageReg.sv
decode/decode.sv
execute/execute.sv
memory/memory.sv
src/proc.sv
bench/procTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module procTb -f vlog.f -o procSim \
   && ./obj_dir/procSim > sim.log 2>&1 \
   || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"
